// File: rtl/ooo_pkg.sv
package ooo_pkg;

    // register file sizes
    localparam int ARCH_REG_SZ  = 8;
    localparam int PHYS_REG_SZ  = 16;
    localparam int FREE_LIST_SZ = PHYS_REG_SZ - ARCH_REG_SZ;

    // reorder buffer depth
    localparam int ROB_SZ = 8;

    // architectural register number
    typedef logic [$clog2(ARCH_REG_SZ)-1:0] arn_t;

    // physical register number
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] prn_t;

    // rob entry number
    typedef logic [$clog2(ROB_SZ)-1:0] robn_t;

    // occupancy counts, one bit wider than the index
    typedef logic [$clog2(ROB_SZ+1)-1:0]       rob_cnt_t;
    typedef logic [$clog2(FREE_LIST_SZ+1)-1:0] fl_cnt_t;

    // never renamed, always maps to prn 0
    localparam arn_t ZERO_REG = '0;

endpackage

// File: rtl/rename_if.sv
`timescale 1ns/10ps

interface rename_if import ooo_pkg::*; ();

    // dispatch side
    logic rename_valid;
    arn_t dest_arn;
    arn_t op1_arn;
    arn_t op2_arn;
    prn_t dest_prn;
    prn_t op1_prn;
    prn_t op2_prn;
    prn_t old_prn;
    logic free_empty;

    // commit side
    logic release_valid;
    prn_t release_prn;
    logic retire_valid;
    arn_t retire_arn;
    prn_t retire_prn;

    modport ctrl (
        output rename_valid, dest_arn, op1_arn, op2_arn,
        output release_valid, release_prn,
        output retire_valid, retire_arn, retire_prn,
        input  dest_prn, op1_prn, op2_prn, old_prn, free_empty
    );

    modport rat (
        input  rename_valid, dest_arn, op1_arn, op2_arn,
        input  release_valid, release_prn,
        input  retire_valid, retire_arn, retire_prn,
        output dest_prn, op1_prn, op2_prn, old_prn, free_empty
    );

endinterface

// File: rtl/rob_if.sv
`timescale 1ns/10ps

interface rob_if import ooo_pkg::*; ();

    // allocation at the tail
    logic  alloc_valid;
    arn_t  alloc_arn;
    prn_t  alloc_prn;
    prn_t  alloc_old_prn;
    robn_t tail_robn;
    logic  full;

    // head presentation and retirement
    logic head_valid;
    arn_t head_arn;
    prn_t head_prn;
    prn_t head_old_prn;
    logic retire;

    modport ctrl (
        output alloc_valid, alloc_arn, alloc_prn, alloc_old_prn, retire,
        input  tail_robn, full, head_valid, head_arn, head_prn, head_old_prn
    );

    modport rob (
        input  alloc_valid, alloc_arn, alloc_prn, alloc_old_prn, retire,
        output tail_robn, full, head_valid, head_arn, head_prn, head_old_prn
    );

endinterface

// File: rtl/rat.sv
`timescale 1ns/10ps

module rat import ooo_pkg::*; (
    input logic   clock,
    input logic   rst_n,
    rename_if.rat ren
);

    // speculative map, read at dispatch
    prn_t map_table [ARCH_REG_SZ];

    // circular free list
    prn_t                              free_list [FREE_LIST_SZ];
    logic [$clog2(FREE_LIST_SZ)-1:0]   fl_head;
    logic [$clog2(FREE_LIST_SZ)-1:0]   fl_tail;
    fl_cnt_t                           fl_cnt;

    // lookups see the map before this cycle's update
    assign ren.dest_prn   = free_list[fl_head];
    assign ren.op1_prn    = map_table[ren.op1_arn];
    assign ren.op2_prn    = map_table[ren.op2_arn];
    assign ren.old_prn    = map_table[ren.dest_arn];
    assign ren.free_empty = (fl_cnt == '0);

    // map table
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                map_table[i] <= prn_t'(i);
            end
        end else begin
            if (ren.rename_valid) begin
                map_table[ren.dest_arn] <= free_list[fl_head];
            end
        end
    end

    // free list, pop at head and push at tail
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < FREE_LIST_SZ; i++) begin
                free_list[i] <= prn_t'(ARCH_REG_SZ + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= fl_cnt_t'(FREE_LIST_SZ);
        end else begin
            if (ren.rename_valid) begin
                fl_head <= fl_head + 1'b1;
            end
            if (ren.release_valid) begin
                free_list[fl_tail] <= ren.release_prn;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({ren.rename_valid, ren.release_valid})
                2'b10: begin
                    fl_cnt <= fl_cnt - 1'b1;
                end
                2'b01: begin
                    fl_cnt <= fl_cnt + 1'b1;
                end
                default: begin
                    fl_cnt <= fl_cnt;
                end
            endcase
        end
    end

endmodule

// File: rtl/rob.sv
`timescale 1ns/10ps

module rob import ooo_pkg::*; (
    input logic  clock,
    input logic  rst_n,
    rob_if.rob   rb,
    input logic  complete_valid,
    input robn_t complete_robn
);

    // entry payload
    arn_t entry_arn     [ROB_SZ];
    prn_t entry_prn     [ROB_SZ];
    prn_t entry_old_prn [ROB_SZ];

    // executed flags
    logic [ROB_SZ-1:0] executed;

    robn_t    head;
    robn_t    tail;
    rob_cnt_t count;

    assign rb.tail_robn    = tail;
    assign rb.full         = (count == rob_cnt_t'(ROB_SZ));
    assign rb.head_valid   = (count != '0) && executed[head];
    assign rb.head_arn     = entry_arn[head];
    assign rb.head_prn     = entry_prn[head];
    assign rb.head_old_prn = entry_old_prn[head];

    // payload written at allocation
    always_ff @(posedge clock) begin
        if (rb.alloc_valid) begin
            entry_arn[tail]     <= rb.alloc_arn;
            entry_prn[tail]     <= rb.alloc_prn;
            entry_old_prn[tail] <= rb.alloc_old_prn;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            executed <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (rb.alloc_valid) begin
                executed[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            // completion may land on any in-flight entry
            if (complete_valid) begin
                executed[complete_robn] <= 1'b1;
            end
            if (rb.retire) begin
                head <= head + 1'b1;
            end
            case ({rb.alloc_valid, rb.retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: rtl/ooo_ctrl.sv
`timescale 1ns/10ps

module ooo_ctrl import ooo_pkg::*; (
    input  logic     dispatch_valid,
    input  arn_t     dest_arn,
    input  arn_t     op1_arn,
    input  arn_t     op2_arn,
    rename_if.ctrl   ren,
    rob_if.ctrl      rb,
    output logic     structural_hazard,
    output logic     issue_valid,
    output prn_t     issue_dest_prn,
    output prn_t     issue_op1_prn,
    output prn_t     issue_op2_prn,
    output robn_t    issue_robn,
    output logic     commit_valid,
    output logic     commit_wr_en,
    output arn_t     commit_arn,
    output prn_t     commit_prn
);

    logic dest_nonzero;
    logic head_nonzero;

    assign dest_nonzero = (dest_arn != ZERO_REG);
    assign head_nonzero = (rb.head_arn != ZERO_REG);

    // free list only matters when a prn is needed
    assign structural_hazard = rb.full || (ren.free_empty && dest_nonzero);
    assign issue_valid       = dispatch_valid && !structural_hazard;

    assign ren.rename_valid = issue_valid && dest_nonzero;
    assign ren.dest_arn     = dest_arn;
    assign ren.op1_arn      = op1_arn;
    assign ren.op2_arn      = op2_arn;

    assign issue_dest_prn = (issue_valid && dest_nonzero) ? ren.dest_prn : '0;
    assign issue_op1_prn  = issue_valid ? ren.op1_prn : '0;
    assign issue_op2_prn  = issue_valid ? ren.op2_prn : '0;
    assign issue_robn     = issue_valid ? rb.tail_robn : '0;

    assign rb.alloc_valid   = issue_valid;
    assign rb.alloc_arn     = dest_arn;
    assign rb.alloc_prn     = issue_dest_prn;
    assign rb.alloc_old_prn = ren.old_prn;

    // in-order retirement from the rob head
    assign commit_valid = rb.head_valid;
    assign commit_wr_en = commit_valid && head_nonzero;
    assign commit_arn   = commit_valid ? rb.head_arn : '0;
    assign commit_prn   = commit_valid ? rb.head_prn : '0;
    assign rb.retire    = commit_valid;

    assign ren.release_valid = commit_wr_en;
    assign ren.release_prn   = rb.head_old_prn;
    assign ren.retire_valid  = commit_wr_en;
    assign ren.retire_arn    = rb.head_arn;
    assign ren.retire_prn    = rb.head_prn;

endmodule

// File: rtl/ooo_top.sv
`timescale 1ns/10ps

module ooo_top import ooo_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,

    input  logic  dispatch_valid,
    input  arn_t  dest_arn,
    input  arn_t  op1_arn,
    input  arn_t  op2_arn,
    input  logic  complete_valid,
    input  robn_t complete_robn,

    output logic  structural_hazard,
    output logic  issue_valid,
    output prn_t  issue_dest_prn,
    output prn_t  issue_op1_prn,
    output prn_t  issue_op2_prn,
    output robn_t issue_robn,
    output logic  commit_valid,
    output logic  commit_wr_en,
    output arn_t  commit_arn,
    output prn_t  commit_prn
);

    rename_if ren_bus ();
    rob_if    rob_bus ();

    rat rat_inst (
        .clock (clock),
        .rst_n (rst_n),
        .ren   (ren_bus.rat)
    );

    // completion strobe comes straight from outside
    rob rob_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .rb             (rob_bus.rob),
        .complete_valid (complete_valid),
        .complete_robn  (complete_robn)
    );

    ooo_ctrl ctrl_inst (
        .dispatch_valid    (dispatch_valid),
        .dest_arn          (dest_arn),
        .op1_arn           (op1_arn),
        .op2_arn           (op2_arn),
        .ren               (ren_bus.ctrl),
        .rb                (rob_bus.ctrl),
        .structural_hazard (structural_hazard),
        .issue_valid       (issue_valid),
        .issue_dest_prn    (issue_dest_prn),
        .issue_op1_prn     (issue_op1_prn),
        .issue_op2_prn     (issue_op2_prn),
        .issue_robn        (issue_robn),
        .commit_valid      (commit_valid),
        .commit_wr_en      (commit_wr_en),
        .commit_arn        (commit_arn),
        .commit_prn        (commit_prn)
    );

endmodule

// File: testbench/ooo_assertions.sv
`timescale 1ns/10ps

module ooo_assertions (
    input logic clock,
    input logic rst_n,
    input logic structural_hazard,
    input logic issue_valid,
    input logic commit_valid,
    input logic commit_wr_en
);

    // a dispatch is never accepted under hazard
    assert property (@(posedge clock) disable iff (!rst_n)
        !(issue_valid && structural_hazard))
        else $error("issue_valid high together with structural_hazard");

    assert property (@(posedge clock) disable iff (!rst_n)
        commit_wr_en |-> commit_valid)
        else $error("commit_wr_en high without commit_valid");

    // one cycle after a reset edge everything is quiet
    assert property (@(posedge clock)
        !rst_n |=> !(issue_valid || commit_valid || commit_wr_en || structural_hazard))
        else $error("outputs active right after reset");

endmodule

bind ooo_top ooo_assertions asrt_inst (
    .clock             (clock),
    .rst_n             (rst_n),
    .structural_hazard (structural_hazard),
    .issue_valid       (issue_valid),
    .commit_valid      (commit_valid),
    .commit_wr_en      (commit_wr_en)
);

// File: testbench/ooo_checker.sv
`timescale 1ns/10ps

module ooo_checker import ooo_pkg::*; (
    input  logic        clock,
    input  logic        check_en,
    input  int          test_id,
    input  logic [39:0] expected,
    input  logic        structural_hazard,
    input  logic        issue_valid,
    input  prn_t        issue_dest_prn,
    input  prn_t        issue_op1_prn,
    input  prn_t        issue_op2_prn,
    input  robn_t       issue_robn,
    input  logic        commit_valid,
    input  logic        commit_wr_en,
    input  arn_t        commit_arn,
    input  prn_t        commit_prn,
    output int          tests_run,
    output int          errors
);

    int n_tests = 0;
    int n_errors = 0;

    assign tests_run = n_tests;
    assign errors    = n_errors;

    task automatic compare_field(input string name, input logic [3:0] exp_val,
                                 input logic [3:0] act_val, inout int mismatches);
        if (act_val !== exp_val) begin
            $display("error: %s expected %h got %h", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    // outputs are settled mid-cycle, well away from both edges
    always @(negedge clock) begin
        int mismatches;
        if (check_en) begin
            mismatches = 0;
            compare_field("structural_hazard", expected[39:36], {3'b0, structural_hazard},
                          mismatches);
            compare_field("issue_valid", expected[35:32], {3'b0, issue_valid}, mismatches);
            compare_field("issue_dest_prn", expected[31:28], issue_dest_prn, mismatches);
            compare_field("issue_op1_prn", expected[27:24], issue_op1_prn, mismatches);
            compare_field("issue_op2_prn", expected[23:20], issue_op2_prn, mismatches);
            compare_field("issue_robn", expected[19:16], {1'b0, issue_robn}, mismatches);
            compare_field("commit_valid", expected[15:12], {3'b0, commit_valid}, mismatches);
            compare_field("commit_wr_en", expected[11:8], {3'b0, commit_wr_en}, mismatches);
            compare_field("commit_arn", expected[7:4], {1'b0, commit_arn}, mismatches);
            compare_field("commit_prn", expected[3:0], commit_prn, mismatches);
            n_tests++;
            n_errors += mismatches;
            if (mismatches == 0) begin
                $display("test %0d: pass", test_id);
            end else begin
                $display("test %0d: fail with %0d mismatches", test_id, mismatches);
            end
        end
    end

endmodule

// File: testbench/ooo_tb.sv
`timescale 1ns/10ps

module ooo_tb import ooo_pkg::*; ();

    logic clock, rst_n, dispatch_valid, complete_valid;
    arn_t dest_arn, op1_arn, op2_arn;
    robn_t complete_robn;
    logic structural_hazard, issue_valid, commit_valid, commit_wr_en;
    prn_t issue_dest_prn, issue_op1_prn, issue_op2_prn, commit_prn;
    robn_t issue_robn;
    arn_t commit_arn;

    logic check_en;
    int test_id;
    logic [39:0] expected;
    int tests_run, errors;

    // one golden row holds 16 hex columns, first column in the top nibble
    logic [63:0] rows [$];
    int cycle_limit = 1000;
    int cycles = 0;

    ooo_top uut (.*);

    ooo_checker checker_inst (.*);

    function automatic logic [3:0] column(input logic [63:0] row, input int k);
        return row[63-4*k -: 4];
    endfunction

    task automatic load_golden();
        int fd;
        int vals [16];
        string line;
        logic [63:0] row;
        fd = $fopen("testbench/ooo_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6],
                        vals[7], vals[8], vals[9], vals[10], vals[11], vals[12],
                        vals[13], vals[14], vals[15]));
                    for (int k = 0; k < 16; k++) begin
                        row[63-4*k -: 4] = vals[k][3:0];
                    end
                    rows.push_back(row);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        dest_arn = '0;
        op1_arn = '0;
        op2_arn = '0;
        complete_valid = 1'b0;
        complete_robn = '0;
        check_en = 1'b0;
        test_id = 0;
        expected = '0;
        load_golden();
        cycle_limit = rows.size() + 3 + 20;
        repeat (3) @(posedge clock);
        foreach (rows[i]) begin
            if (i > 0) begin
                @(posedge clock);
            end
            #10;
            rst_n = 1'b1;
            dispatch_valid = 1'(column(rows[i], 0));
            dest_arn = arn_t'(column(rows[i], 1));
            op1_arn = arn_t'(column(rows[i], 2));
            op2_arn = arn_t'(column(rows[i], 3));
            complete_valid = 1'(column(rows[i], 4));
            complete_robn = robn_t'(column(rows[i], 5));
            expected = rows[i][39:0];
            test_id = i + 1;
            check_en = 1'b1;
        end
        @(posedge clock);
        #10;
        check_en = 1'b0;
        dispatch_valid = 1'b0;
        complete_valid = 1'b0;
        $display("tests run %0d, expected %0d, mismatches %0d", tests_run, rows.size(), errors);
        if (errors == 0 && tests_run == rows.size() && rows.size() > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: testbench/ooo_golden.txt
# dispatch_valid dest_arn op1_arn op2_arn complete_valid complete_robn | expected: structural_hazard
# issue_valid issue_dest_prn issue_op1_prn issue_op2_prn issue_robn commit_valid commit_wr_en commit_arn commit_prn
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 1 8 0 0 0 0 0 0 0
1 2 1 0 0 0 0 1 9 8 0 1 0 0 0 0
1 3 2 3 0 0 0 1 a 9 3 2 0 0 0 0
1 0 3 1 1 2 0 1 0 a 8 3 0 0 0 0
0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 1 1 0 0 0 0 0 0 1 1 1 8
0 0 0 0 0 0 0 0 0 0 0 0 1 1 2 9
0 0 0 0 0 0 0 0 0 0 0 0 1 1 3 a
0 0 0 0 1 3 0 0 0 0 0 0 0 0 0 0
1 4 1 2 0 0 0 1 b 8 9 4 1 0 0 0
1 5 4 0 0 0 0 1 c b 0 5 0 0 0 0
1 6 5 6 0 0 0 1 d c 6 6 0 0 0 0
1 7 0 0 0 0 0 1 e 0 0 7 0 0 0 0
1 1 1 0 0 0 0 1 f 8 0 0 0 0 0 0
1 2 0 0 0 0 0 1 1 0 0 1 0 0 0 0
1 3 0 0 0 0 0 1 2 0 0 2 0 0 0 0
1 4 0 0 0 0 0 1 3 0 0 3 0 0 0 0
1 5 0 0 1 4 1 0 0 0 0 0 0 0 0 0
1 5 0 0 1 5 1 0 0 0 0 0 1 1 4 b
1 5 5 0 0 0 0 1 4 c 0 4 1 1 5 c
1 0 5 0 0 0 0 1 0 4 0 5 0 0 0 0
1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0

// File: filelist.f
rtl/ooo_pkg.sv
rtl/rename_if.sv
rtl/rob_if.sv
rtl/rat.sv
rtl/rob.sv
rtl/ooo_ctrl.sv
rtl/ooo_top.sv
testbench/ooo_assertions.sv
testbench/ooo_checker.sv
testbench/ooo_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ooo_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
